//--- hdl/hsdom_pkg.sv
package hsdom_pkg;

    localparam int NUM_MSTS  = 3;
    localparam int NUM_BANKS = 2;

    localparam int MST_IDX_W = $clog2(NUM_MSTS);

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam int BANK_WORDS = 64;
    localparam int WORD_IDX_W = $clog2(BANK_WORDS);
    localparam int BANK_BYTES = BANK_WORDS * STRB_W;
    localparam int WIN_LSB    = $clog2(BANK_BYTES); // Address bits below this index a window.

    // Each window is BANK_BYTES long, starting at its base.
    localparam logic [ADDR_W-1:0] BANK0_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] BANK1_BASE = 16'h1000;

    localparam int RESP_W = 2;

    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } resp_e;

    // One transaction at a time moves through these states in order.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_WRESP,
        ST_RRESP
    } fabric_state_e;

endpackage

//--- hdl/hsdom_arbiter.sv
`timescale 1ns/100ps

module hsdom_arbiter import hsdom_pkg::*; (
    input  logic                 seq,
    input  logic                 rst_n,
    input  logic [NUM_MSTS-1:0]  req_write,
    input  logic [NUM_MSTS-1:0]  req_read,
    input  logic                 pause,
    input  logic                 take,
    output logic                 grant_valid,
    output logic [MST_IDX_W-1:0] grant_idx,
    output logic                 grant_write
);

    logic [MST_IDX_W-1:0] ptr;
    logic [NUM_MSTS-1:0]  req_any;
    logic                 found;
    logic [MST_IDX_W-1:0] pick;

    assign req_any = req_write | req_read;

    // Search starts at the pointer and wraps around the masters.
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < NUM_MSTS; i++) begin
            cand = int'(ptr) + i;
            if (cand >= NUM_MSTS) begin
                cand = cand - NUM_MSTS;
            end
            if (!found && req_any[cand]) begin
                found = 1'b1;
                pick  = MST_IDX_W'(cand);
            end
        end
    end

    assign grant_valid = found && !pause; // Pause holds back every new grant.
    assign grant_idx   = pick;
    assign grant_write = req_write[pick]; // A pending write beats a read of the same master.

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (take) begin
            // Next search begins just past the master that was served.
            if (grant_idx == MST_IDX_W'(NUM_MSTS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

//--- hdl/hsdom_decoder.sv
`timescale 1ns/100ps

module hsdom_decoder import hsdom_pkg::*; (
    input  logic [ADDR_W-1:0]     addr,
    output logic [NUM_BANKS-1:0]  bank_sel,
    output logic [WORD_IDX_W-1:0] word_idx,
    output logic                  dec_err
);

    logic in_win0;
    logic in_win1;

    // Only the bits above the window size take part in the match.
    assign in_win0 = (addr[ADDR_W-1:WIN_LSB] == BANK0_BASE[ADDR_W-1:WIN_LSB]);
    assign in_win1 = (addr[ADDR_W-1:WIN_LSB] == BANK1_BASE[ADDR_W-1:WIN_LSB]);

    assign bank_sel = {in_win1, in_win0};

    // Byte offset within the word is dropped.
    assign word_idx = addr[WIN_LSB-1:2];

    assign dec_err = !(in_win0 || in_win1);

endmodule

//--- hdl/hsdom_fabric.sv
`timescale 1ns/100ps

module hsdom_fabric import hsdom_pkg::*; (
    input  logic                                 seq,
    input  logic                                 rst_n,

    input  logic [NUM_MSTS-1:0]                  aw_valid,
    output logic [NUM_MSTS-1:0]                  aw_ready,
    input  logic [NUM_MSTS-1:0][ADDR_W-1:0]      aw_addr,
    input  logic [NUM_MSTS-1:0]                  w_valid,
    output logic [NUM_MSTS-1:0]                  w_ready,
    input  logic [NUM_MSTS-1:0][DATA_W-1:0]      w_data,
    input  logic [NUM_MSTS-1:0][STRB_W-1:0]      w_strb,
    output logic [NUM_MSTS-1:0]                  b_valid,
    input  logic [NUM_MSTS-1:0]                  b_ready,
    output logic [NUM_MSTS-1:0][RESP_W-1:0]      b_resp,
    input  logic [NUM_MSTS-1:0]                  ar_valid,
    output logic [NUM_MSTS-1:0]                  ar_ready,
    input  logic [NUM_MSTS-1:0][ADDR_W-1:0]      ar_addr,
    output logic [NUM_MSTS-1:0]                  r_valid,
    input  logic [NUM_MSTS-1:0]                  r_ready,
    output logic [NUM_MSTS-1:0][DATA_W-1:0]      r_data,
    output logic [NUM_MSTS-1:0][RESP_W-1:0]      r_resp,

    input  logic                                 grant_valid,
    input  logic [MST_IDX_W-1:0]                 grant_idx,
    input  logic                                 grant_write,
    output logic                                 take,

    output logic [ADDR_W-1:0]                    dec_addr,
    input  logic [NUM_BANKS-1:0]                 bank_sel,
    input  logic [WORD_IDX_W-1:0]                word_idx,
    input  logic                                 dec_err,

    output logic [NUM_BANKS-1:0]                 bank_req,
    output logic                                 bank_we,
    output logic [WORD_IDX_W-1:0]                bank_idx,
    output logic [DATA_W-1:0]                    bank_wdata,
    output logic [STRB_W-1:0]                    bank_strb,
    input  logic [NUM_BANKS-1:0][DATA_W-1:0]     bank_rdata,

    input  logic                                 pause,
    output logic                                 pause_ack
);

    fabric_state_e        state;
    logic [MST_IDX_W-1:0] cur_idx;
    logic                 cur_write;
    logic [ADDR_W-1:0]    cur_addr;
    logic [DATA_W-1:0]    cur_data;
    logic [STRB_W-1:0]    cur_strb;
    resp_e                resp;
    logic [DATA_W-1:0]    rd_word;

    assign take      = (state == ST_IDLE) && grant_valid;
    assign pause_ack = pause && (state == ST_IDLE);

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            cur_idx   <= '0;
            cur_write <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state     <= ST_ACCESS;
                        cur_idx   <= grant_idx;
                        cur_write <= grant_write;
                    end
                end
                ST_ACCESS: state <= cur_write ? ST_WRESP : ST_RRESP;
                ST_WRESP: begin
                    if (b_ready[cur_idx]) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RRESP: begin
                    if (r_ready[cur_idx]) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // The payload is captured in the same cycle as the address and data handshakes.
    always_ff @(posedge seq) begin
        if (take) begin
            cur_addr <= grant_write ? aw_addr[grant_idx] : ar_addr[grant_idx];
            cur_data <= w_data[grant_idx];
            cur_strb <= w_strb[grant_idx];
        end
    end

    // The latched address keeps the decode stable until the response is accepted.
    assign dec_addr = cur_addr;

    assign bank_req   = (state == ST_ACCESS && !dec_err) ? bank_sel : '0;
    assign bank_we    = cur_write;
    assign bank_idx   = word_idx;
    assign bank_wdata = cur_data;
    assign bank_strb  = cur_strb;

    always_comb begin
        rd_word = '0; // Stays zero on a decode error, since no bank is selected.
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_sel[b]) begin
                rd_word = bank_rdata[b];
            end
        end
    end

    assign resp = dec_err ? RESP_DECERR : RESP_OKAY;

    always_comb begin
        for (int m = 0; m < NUM_MSTS; m++) begin
            aw_ready[m] = take && grant_write && (grant_idx == MST_IDX_W'(m));
            w_ready[m]  = take && grant_write && (grant_idx == MST_IDX_W'(m));
            ar_ready[m] = take && !grant_write && (grant_idx == MST_IDX_W'(m));
            b_valid[m]  = (state == ST_WRESP) && (cur_idx == MST_IDX_W'(m));
            r_valid[m]  = (state == ST_RRESP) && (cur_idx == MST_IDX_W'(m));
            b_resp[m]   = resp;
            r_resp[m]   = resp;
            r_data[m]   = r_valid[m] ? rd_word : '0;
        end
    end

endmodule

//--- hdl/hsdom_mem_bank.sv
`timescale 1ns/100ps

module hsdom_mem_bank import hsdom_pkg::*; (
    input  logic                  seq,
    input  logic                  req,
    input  logic                  we,
    input  logic [WORD_IDX_W-1:0] idx,
    input  logic [DATA_W-1:0]     wdata,
    input  logic [STRB_W-1:0]     strb,
    output logic [DATA_W-1:0]     rdata
);

    logic [DATA_W-1:0] mem [BANK_WORDS];

    // Each strobe bit enables one byte lane of the write.
    always_ff @(posedge seq) begin
        if (req && we) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Read data holds its value until the next read request.
    always_ff @(posedge seq) begin
        if (req && !we) begin
            rdata <= mem[idx];
        end
    end

endmodule

//--- hdl/hsdom_top.sv
`timescale 1ns/100ps

module hsdom_top import hsdom_pkg::*; (
    input  logic                             seq,
    input  logic                             rst_n,
    input  logic                             pause,
    output logic                             pause_ack,

    input  logic [NUM_MSTS-1:0]              aw_valid,
    output logic [NUM_MSTS-1:0]              aw_ready,
    input  logic [NUM_MSTS-1:0][ADDR_W-1:0]  aw_addr,
    input  logic [NUM_MSTS-1:0]              w_valid,
    output logic [NUM_MSTS-1:0]              w_ready,
    input  logic [NUM_MSTS-1:0][DATA_W-1:0]  w_data,
    input  logic [NUM_MSTS-1:0][STRB_W-1:0]  w_strb,
    output logic [NUM_MSTS-1:0]              b_valid,
    input  logic [NUM_MSTS-1:0]              b_ready,
    output logic [NUM_MSTS-1:0][RESP_W-1:0]  b_resp,
    input  logic [NUM_MSTS-1:0]              ar_valid,
    output logic [NUM_MSTS-1:0]              ar_ready,
    input  logic [NUM_MSTS-1:0][ADDR_W-1:0]  ar_addr,
    output logic [NUM_MSTS-1:0]              r_valid,
    input  logic [NUM_MSTS-1:0]              r_ready,
    output logic [NUM_MSTS-1:0][DATA_W-1:0]  r_data,
    output logic [NUM_MSTS-1:0][RESP_W-1:0]  r_resp
);

    logic                             grant_valid;
    logic [MST_IDX_W-1:0]             grant_idx;
    logic                             grant_write;
    logic                             take;

    logic [ADDR_W-1:0]                dec_addr;
    logic [NUM_BANKS-1:0]             bank_sel;
    logic [WORD_IDX_W-1:0]            word_idx;
    logic                             dec_err;

    logic [NUM_BANKS-1:0]             bank_req;
    logic                             bank_we;
    logic [WORD_IDX_W-1:0]            bank_idx;
    logic [DATA_W-1:0]                bank_wdata;
    logic [STRB_W-1:0]                bank_strb;
    logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;

    // A write needs both its address and its data before it may compete.
    hsdom_arbiter hsdom_arbiter_i (
        .seq         (seq),
        .rst_n       (rst_n),
        .req_write   (aw_valid & w_valid),
        .req_read    (ar_valid),
        .pause       (pause),
        .take        (take),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_write (grant_write)
    );

    hsdom_decoder hsdom_decoder_i (
        .addr     (dec_addr),
        .bank_sel (bank_sel),
        .word_idx (word_idx),
        .dec_err  (dec_err)
    );

    hsdom_fabric hsdom_fabric_i (
        .seq         (seq),
        .rst_n       (rst_n),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw_addr     (aw_addr),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w_data      (w_data),
        .w_strb      (w_strb),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b_resp      (b_resp),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar_addr     (ar_addr),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_write (grant_write),
        .take        (take),
        .dec_addr    (dec_addr),
        .bank_sel    (bank_sel),
        .word_idx    (word_idx),
        .dec_err     (dec_err),
        .bank_req    (bank_req),
        .bank_we     (bank_we),
        .bank_idx    (bank_idx),
        .bank_wdata  (bank_wdata),
        .bank_strb   (bank_strb),
        .bank_rdata  (bank_rdata),
        .pause       (pause),
        .pause_ack   (pause_ack)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
        hsdom_mem_bank hsdom_mem_bank_i (
            .seq   (seq),
            .req   (bank_req[b]),
            .we    (bank_we),
            .idx   (bank_idx),
            .wdata (bank_wdata),
            .strb  (bank_strb),
            .rdata (bank_rdata[b])
        );
    end

endmodule

//--- test/hsdom_props.sv
`timescale 1ns/100ps

module hsdom_props import hsdom_pkg::*; (
    input logic                 seq,
    input logic                 rst_n,
    input logic [NUM_MSTS-1:0]  aw_ready,
    input logic [NUM_MSTS-1:0]  ar_ready,
    input logic [NUM_MSTS-1:0]  b_valid,
    input logic [NUM_MSTS-1:0]  r_valid,
    input logic [NUM_BANKS-1:0] bank_req,
    input logic                 dec_err
);

    int fail_count = 0;

    single_ready: assert property (@(posedge seq) disable iff (!rst_n)
        $onehot0({aw_ready, ar_ready}))
        else begin
            fail_count++;
            $error("More than one address ready is high.");
        end

    // Only one transaction is open, so write and read responses never overlap.
    resp_exclusive: assert property (@(posedge seq) disable iff (!rst_n)
        !((|b_valid) && (|r_valid)))
        else begin
            fail_count++;
            $error("A write response and a read response are valid together.");
        end

    no_req_on_decerr: assert property (@(posedge seq) disable iff (!rst_n)
        !((|bank_req) && dec_err))
        else begin
            fail_count++;
            $error("A bank was strobed for an unmapped address.");
        end

endmodule

bind hsdom_fabric hsdom_props hsdom_props_i (
    .seq      (seq),
    .rst_n    (rst_n),
    .aw_ready (aw_ready),
    .ar_ready (ar_ready),
    .b_valid  (b_valid),
    .r_valid  (r_valid),
    .bank_req (bank_req),
    .dec_err  (dec_err)
);

//--- test/hsdom_checker.sv
`timescale 1ns/100ps

module hsdom_checker import hsdom_pkg::*; (
    input  logic                             seq,
    input  logic                             rst_n,
    input  logic                             pause,
    input  logic                             pause_ack,
    input  logic [NUM_MSTS-1:0]              aw_valid,
    input  logic [NUM_MSTS-1:0]              w_valid,
    input  logic [NUM_MSTS-1:0]              ar_valid,
    input  logic [NUM_MSTS-1:0]              aw_ready,
    input  logic [NUM_MSTS-1:0]              w_ready,
    input  logic [NUM_MSTS-1:0]              ar_ready,
    input  logic [NUM_MSTS-1:0]              b_valid,
    input  logic [NUM_MSTS-1:0]              b_ready,
    input  logic [NUM_MSTS-1:0][RESP_W-1:0]  b_resp,
    input  logic [NUM_MSTS-1:0]              r_valid,
    input  logic [NUM_MSTS-1:0]              r_ready,
    input  logic [NUM_MSTS-1:0][RESP_W-1:0]  r_resp,
    input  logic [NUM_MSTS-1:0][DATA_W-1:0]  r_data,
    input  logic                             exp_push,
    input  logic [MST_IDX_W-1:0]             exp_mst,
    input  logic                             exp_write,
    input  logic [RESP_W-1:0]                exp_resp,
    input  logic [DATA_W-1:0]                exp_data,
    output int                               value_errs,
    output int                               proto_errs,
    output int                               done_count
);

    logic [DATA_W+RESP_W:0] exp_q [NUM_MSTS][$]; // {write, resp, data} per master.
    logic [MST_IDX_W-1:0]   ptr;
    logic                   busy; // High from a grant until its response is accepted.

    task automatic check_response(input int m, input logic is_write);
        logic [DATA_W+RESP_W:0] ent;
        if (exp_q[m].size() == 0) begin
            proto_errs++;
            $display("Master %0d got a response that no pattern line expected.", m);
        end else begin
            ent = exp_q[m].pop_front();
            done_count++;
            if (ent[DATA_W+RESP_W] != is_write) begin
                proto_errs++;
                $display("Master %0d got a response on the wrong channel.", m);
            end else if (is_write && b_resp[m] != ent[DATA_W +: RESP_W]) begin
                value_errs++;
                $display("Fail %0t b_resp[%0d] got %0h expected %0h",
                         $time, m, b_resp[m], ent[DATA_W +: RESP_W]);
            end else if (!is_write) begin
                if (r_resp[m] != ent[DATA_W +: RESP_W]) begin
                    value_errs++;
                    $display("Fail %0t r_resp[%0d] got %0h expected %0h",
                             $time, m, r_resp[m], ent[DATA_W +: RESP_W]);
                end
                if (r_data[m] != ent[DATA_W-1:0]) begin
                    value_errs++;
                    $display("Fail %0t r_data[%0d] got %h expected %h",
                             $time, m, r_data[m], ent[DATA_W-1:0]);
                end
            end
        end
    endtask

    always @(posedge seq) begin
        logic [NUM_MSTS-1:0] wreq;
        logic [NUM_MSTS-1:0] req;
        logic                exp_aw;
        logic                exp_ar;
        logic                exp_ack;
        int want;
        int cand;
        if (!rst_n) begin
            ptr        = '0;
            busy       = 1'b0;
            value_errs = 0;
            proto_errs = 0;
            done_count = 0;
        end else begin
            if (exp_push) begin
                exp_q[exp_mst].push_back({exp_write, exp_resp, exp_data});
            end
            // The next master due is the first requester at or after the pointer.
            wreq = aw_valid & w_valid;
            req  = wreq | ar_valid;
            want = -1;
            if (!busy && !pause) begin // Grants happen only in an idle, unpaused fabric.
                for (int i = 0; i < NUM_MSTS; i++) begin
                    cand = (int'(ptr) + i) % NUM_MSTS;
                    if (want < 0 && req[cand]) begin
                        want = cand;
                    end
                end
            end
            exp_ack = pause && !busy;
            if (pause_ack != exp_ack) begin
                value_errs++;
                $display("Fail %0t pause_ack got %0b expected %0b", $time, pause_ack, exp_ack);
            end
            for (int m = 0; m < NUM_MSTS; m++) begin
                exp_aw = (m == want) && wreq[m]; // The write of a master goes first.
                exp_ar = (m == want) && !wreq[m];
                if (aw_ready[m] != exp_aw) begin
                    value_errs++;
                    $display("Fail %0t aw_ready[%0d] got %0b expected %0b",
                             $time, m, aw_ready[m], exp_aw);
                end
                if (w_ready[m] != exp_aw) begin
                    value_errs++;
                    $display("Fail %0t w_ready[%0d] got %0b expected %0b",
                             $time, m, w_ready[m], exp_aw);
                end
                if (ar_ready[m] != exp_ar) begin
                    value_errs++;
                    $display("Fail %0t ar_ready[%0d] got %0b expected %0b",
                             $time, m, ar_ready[m], exp_ar);
                end
                if (aw_ready[m] || ar_ready[m]) begin
                    ptr  = (m == NUM_MSTS - 1) ? '0 : MST_IDX_W'(m + 1);
                    busy = 1'b1;
                end
                if (b_valid[m] && b_ready[m]) begin
                    check_response(m, 1'b1);
                    busy = 1'b0;
                end
                if (r_valid[m] && r_ready[m]) begin
                    check_response(m, 1'b0);
                    busy = 1'b0;
                end
            end
        end
    end

endmodule

//--- test/hsdom_tb.sv
`timescale 1ns/100ps

module hsdom_tb import hsdom_pkg::*; ();

    localparam int NUM_FIELDS = 9;
    localparam int PAT_MAX    = 40;
    localparam int PAUSE_HOLD = 12;
    localparam int F_GRP      = 0;
    localparam int F_HOLD     = 1;
    localparam int F_MST      = 2;
    localparam int F_OP       = 3;
    localparam int F_ADDR     = 4;
    localparam int F_DATA     = 5;
    localparam int F_STRB     = 6;
    localparam int F_RESP     = 7;
    localparam int F_RDATA    = 8;

    logic                             seq;
    logic                             rst_n;
    logic                             pause;
    logic                             pause_ack;
    logic [NUM_MSTS-1:0]              aw_valid;
    logic [NUM_MSTS-1:0]              aw_ready;
    logic [NUM_MSTS-1:0][ADDR_W-1:0]  aw_addr;
    logic [NUM_MSTS-1:0]              w_valid;
    logic [NUM_MSTS-1:0]              w_ready;
    logic [NUM_MSTS-1:0][DATA_W-1:0]  w_data;
    logic [NUM_MSTS-1:0][STRB_W-1:0]  w_strb;
    logic [NUM_MSTS-1:0]              b_valid;
    logic [NUM_MSTS-1:0]              b_ready;
    logic [NUM_MSTS-1:0][RESP_W-1:0]  b_resp;
    logic [NUM_MSTS-1:0]              ar_valid;
    logic [NUM_MSTS-1:0]              ar_ready;
    logic [NUM_MSTS-1:0][ADDR_W-1:0]  ar_addr;
    logic [NUM_MSTS-1:0]              r_valid;
    logic [NUM_MSTS-1:0]              r_ready;
    logic [NUM_MSTS-1:0][DATA_W-1:0]  r_data;
    logic [NUM_MSTS-1:0][RESP_W-1:0]  r_resp;

    logic                             exp_push;
    logic [MST_IDX_W-1:0]             exp_mst;
    logic                             exp_write;
    logic [RESP_W-1:0]                exp_resp;
    logic [DATA_W-1:0]                exp_data;
    int                               value_errs;
    int                               proto_errs;
    int                               done_count;

    logic [31:0] pat [PAT_MAX*NUM_FIELDS];
    int          drv_q [NUM_MSTS][$]; // Line numbers waiting on each master.
    int          n_lines;
    int          other_errs;
    int          assert_errs;
    logic        loaded;

    hsdom_top hsdom_top_i (.*);

    hsdom_checker hsdom_checker_i (.*);

    always #50 seq = ~seq;

    task automatic queue_expect(input int line);
        int base;
        base = line * NUM_FIELDS;
        @(negedge seq);
        exp_push  = 1'b1;
        exp_mst   = pat[base+F_MST][MST_IDX_W-1:0];
        exp_write = pat[base+F_OP][0];
        exp_resp  = pat[base+F_RESP][RESP_W-1:0];
        exp_data  = pat[base+F_RDATA];
    endtask

    task automatic drive_master(input int m);
        int base;
        int delay;
        while (drv_q[m].size() > 0) begin
            base = drv_q[m].pop_front() * NUM_FIELDS;
            @(negedge seq);
            if (pat[base+F_OP][0]) begin
                aw_addr[m]  = pat[base+F_ADDR][ADDR_W-1:0];
                w_data[m]   = pat[base+F_DATA];
                w_strb[m]   = pat[base+F_STRB][STRB_W-1:0];
                aw_valid[m] = 1'b1;
                w_valid[m]  = 1'b1;
                do @(posedge seq); while (!aw_ready[m]);
                @(negedge seq);
                aw_valid[m] = 1'b0;
                w_valid[m]  = 1'b0;
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge seq);
                b_ready[m] = 1'b1;
                do @(posedge seq); while (!b_valid[m]);
                @(negedge seq);
                b_ready[m] = 1'b0;
            end else begin
                ar_addr[m]  = pat[base+F_ADDR][ADDR_W-1:0];
                ar_valid[m] = 1'b1;
                do @(posedge seq); while (!ar_ready[m]);
                @(negedge seq);
                ar_valid[m] = 1'b0;
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge seq);
                r_ready[m] = 1'b1;
                do @(posedge seq); while (!r_valid[m]);
                @(negedge seq);
                r_ready[m] = 1'b0;
            end
        end
    endtask

    // All masters raise their requests on the same edge.
    task automatic drive_group();
        fork
            drive_master(0);
            drive_master(1);
            drive_master(2);
        join
    endtask

    initial begin
        int line;
        int grp;
        logic hold;
        seq = 1'b0;
        rst_n = 1'b0;
        pause = 1'b0;
        aw_valid = '0;
        aw_addr = '0;
        w_valid = '0;
        w_data = '0;
        w_strb = '0;
        b_ready = '0;
        ar_valid = '0;
        ar_addr = '0;
        r_ready = '0;
        exp_push = 1'b0;
        exp_mst = '0;
        exp_write = 1'b0;
        exp_resp = '0;
        exp_data = '0;
        other_errs = 0;
        loaded = 1'b0;
        void'($urandom(32'h2b7748be));
        for (int i = 0; i < PAT_MAX * NUM_FIELDS; i++) begin
            pat[i] = 32'hffff_ffff; // Marks the end of the loaded lines.
        end
        $readmemh("test/hsdom_patterns.txt", pat);
        n_lines = 0;
        while (n_lines < PAT_MAX && pat[n_lines*NUM_FIELDS+F_GRP] != 32'hffff_ffff) begin
            n_lines++;
        end
        loaded = 1'b1;
        if (n_lines == 0) begin
            other_errs++;
            $display("The pattern file held no transactions.");
        end
        repeat (3) @(posedge seq);
        @(negedge seq);
        rst_n = 1'b1;
        line = 0;
        while (line < n_lines) begin
            grp  = pat[line*NUM_FIELDS+F_GRP];
            hold = 1'b0;
            while (line < n_lines && pat[line*NUM_FIELDS+F_GRP] == grp) begin
                queue_expect(line);
                drv_q[pat[line*NUM_FIELDS+F_MST]].push_back(line);
                hold = hold | pat[line*NUM_FIELDS+F_HOLD][0];
                line++;
            end
            @(negedge seq);
            exp_push = 1'b0;
            if (hold) begin
                // Pause rises while the first transaction of the group is in flight.
                fork
                    drive_group();
                    begin
                        do @(posedge seq); while (!((|aw_ready) || (|ar_ready)));
                        @(negedge seq);
                        pause = 1'b1;
                        do @(posedge seq); while (!pause_ack);
                        repeat (PAUSE_HOLD) @(negedge seq);
                        pause = 1'b0;
                    end
                join
            end else begin
                drive_group();
            end
        end
        repeat (4) @(negedge seq);
        if (done_count != n_lines) begin
            other_errs++;
            $display("Only %0d of %0d expected responses were seen.", done_count, n_lines);
        end
        assert_errs = hsdom_top_i.hsdom_fabric_i.hsdom_props_i.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d assertion, %0d other",
                 value_errs, proto_errs, assert_errs, other_errs);
        if (value_errs + proto_errs + assert_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of pattern lines and the pause hold.
    initial begin
        wait (loaded);
        repeat (n_lines * 40 + PAUSE_HOLD + 10) @(posedge seq);
        $display("Timeout: the transactions did not finish in the allowed number of cycles.");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- test/hsdom_patterns.txt
// Columns in hex: group hold master op(1 write, 0 read) addr wdata strb resp rdata.
// Lines of one group are issued together; hold 1 issues the group while pause is high.
0 0 0 1 0000 A0A0A0A0 F 0 00000000
0 0 1 1 00FC B1B1B1B1 F 0 00000000
0 0 2 1 1000 C2C2C2C2 F 0 00000000
1 0 0 1 10FC D0D0D0D0 F 0 00000000
1 0 1 0 0000 00000000 0 0 A0A0A0A0
1 0 2 0 00FC 00000000 0 0 B1B1B1B1
2 0 0 0 1000 00000000 0 0 C2C2C2C2
2 0 1 0 10FC 00000000 0 0 D0D0D0D0
2 0 2 1 0004 12345678 F 0 00000000
3 0 0 1 1008 CAFEF00D F 0 00000000
3 0 1 1 1004 55AA55AA F 0 00000000
3 0 2 0 0000 00000000 0 0 A0A0A0A0
4 0 0 1 0004 AABBCCDD 5 0 00000000
4 0 1 1 1008 99887766 A 0 00000000
4 0 2 1 1004 01020304 8 0 00000000
5 0 0 0 1008 00000000 0 0 99FE770D
5 0 1 0 1004 00000000 0 0 01AA55AA
5 0 2 0 0004 00000000 0 0 12BB56DD
6 0 0 1 0800 DEADBEEF F 3 00000000
6 0 1 0 2000 00000000 0 3 00000000
6 0 2 1 2000 0BADF00D F 3 00000000
7 1 0 0 0800 00000000 0 3 00000000
7 1 1 0 0000 00000000 0 0 A0A0A0A0
7 1 2 0 1000 00000000 0 0 C2C2C2C2
8 0 0 0 00FC 00000000 0 0 B1B1B1B1
8 0 1 0 1000 00000000 0 0 C2C2C2C2
8 0 2 0 FFFC 00000000 0 3 00000000

//--- sources.f
hdl/hsdom_pkg.sv
hdl/hsdom_arbiter.sv
hdl/hsdom_decoder.sv
hdl/hsdom_fabric.sv
hdl/hsdom_mem_bank.sv
hdl/hsdom_top.sv
test/hsdom_props.sv
test/hsdom_checker.sv
test/hsdom_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the simulation with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module hsdom_tb -Mdir obj_dir -o hsdom_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/hsdom_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
